// File: vlog.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/mips_ifs.sv
rtl/register_file.sv
rtl/alu.sv
rtl/execute_stage.sv
rtl/mips_exec_top.sv
sim/tb_mips_exec.sv

// File: Bender.yml
package:
  name: mips_exec

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mips_pkg.sv
      - rtl/mips_ifs.sv
      - rtl/register_file.sv
      - rtl/alu.sv
      - rtl/execute_stage.sv
      - rtl/mips_exec_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_mips_exec.sv

// File: sim/tb_mips_exec.sv
`timescale 1ns/100ps
`include "mips_defs.svh"

module tb_mips_exec;

    localparam int TIMEOUT_CYCLES = 20;   // Per-op wait limit
    localparam int RAND_OPS       = 200;

    typedef struct {
        string               name;
        mips_pkg::alu_sel_t  op;
        mips_pkg::reg_addr_t ra0, ra1, wa;
        mips_pkg::imm_t      imm;
        logic                write;
        logic                b2b;         // Issued in the cycle after the previous op
        logic                use_model;   // Expected values come from the model
        mips_pkg::word_t     exp_res;
        logic                exp_zero;
        mips_pkg::word_t     exp_dbg;     // Readback of wa after the op
    } entry_t;

    logic                clock, reset, valid, write, zero, result_valid;
    mips_pkg::alu_sel_t  op;
    mips_pkg::reg_addr_t ra0, ra1, wa, dbg_addr;
    mips_pkg::imm_t      imm;
    mips_pkg::word_t     dbg_data, result;

    entry_t          tbl[$];
    mips_pkg::word_t model [`MIPS_REG_COUNT];   // Register file mirror
    mips_pkg::word_t model_hi, model_lo;

    mips_exec_top i_mips_exec_top (.*);

    always #20 clock = ~clock;

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic stop_on_failure();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input mips_pkg::word_t exp,
                              input mips_pkg::word_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_zero(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected zero=%b, actual zero=%b", name, exp, act);
            stop_on_failure();
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // MULT, DIV and codes 12..15 never reach a register
    function automatic logic writes_reg(input mips_pkg::alu_sel_t sel);
        return (sel <= mips_pkg::ALU_PASS) && (sel != mips_pkg::ALU_MULT) &&
               (sel != mips_pkg::ALU_DIV);
    endfunction

    function automatic mips_pkg::word_t model_result(input mips_pkg::alu_sel_t sel,
                                                     input mips_pkg::word_t a, b);
        mips_pkg::word_t r;
        case (sel)
            mips_pkg::ALU_ADD:  r = a + b;
            mips_pkg::ALU_SUB:  r = a - b;
            mips_pkg::ALU_AND:  r = a & b;
            mips_pkg::ALU_OR:   r = a | b;
            mips_pkg::ALU_MFHI: r = model_hi;
            mips_pkg::ALU_MFLO: r = model_lo;
            default:            r = '0;
        endcase
        return r;
    endfunction

    task automatic add_entry(input string name, input mips_pkg::alu_sel_t sel,
                             input mips_pkg::reg_addr_t s0, s1, d, input mips_pkg::imm_t im,
                             input logic wr, b2b, input mips_pkg::word_t exp, input logic ez);
        entry_t e;
        e = '{name, sel, s0, s1, d, im, wr, b2b, 1'b0, exp, ez, '0};
        tbl.push_back(e);
    endtask

    ////////////////////////////////////////
    // Issue and wait
    ////////////////////////////////////////

    // Model sees the op at issue, so a following op reads the new state
    task automatic drive_entry(input int idx);
        mips_pkg::word_t           a;
        mips_pkg::word_t           b;
        logic [2*`MIPS_WORD_W-1:0] prod;
        a = model[tbl[idx].ra0];
        b = model[tbl[idx].ra1];
        if (tbl[idx].use_model) begin
            tbl[idx].exp_res  = model_result(tbl[idx].op, a, b);
            tbl[idx].exp_zero = (tbl[idx].exp_res == '0);
        end
        if (tbl[idx].op == mips_pkg::ALU_MULT) begin
            prod     = {{`MIPS_WORD_W{1'b0}}, a} * {{`MIPS_WORD_W{1'b0}}, b};
            model_hi = prod[2*`MIPS_WORD_W-1:`MIPS_WORD_W];
            model_lo = prod[`MIPS_WORD_W-1:0];
        end else if (tbl[idx].op == mips_pkg::ALU_DIV) begin
            model_hi = (b == '0) ? '0 : a / b;   // Quotient
            model_lo = (b == '0) ? '0 : a % b;   // Remainder
        end
        if (tbl[idx].write && writes_reg(tbl[idx].op) && tbl[idx].wa != '0)
            model[tbl[idx].wa] = tbl[idx].exp_res;
        tbl[idx].exp_dbg = model[tbl[idx].wa];
        valid <= 1'b1;
        op    <= tbl[idx].op;
        ra0   <= tbl[idx].ra0;
        ra1   <= tbl[idx].ra1;
        wa    <= tbl[idx].wa;
        imm   <= tbl[idx].imm;
        write <= tbl[idx].write;
    endtask

    task automatic wait_result(input string name);
        int waited;
        waited = 0;
        @(negedge clock);
        while (!result_valid) begin
            waited++;
            if (waited >= TIMEOUT_CYCLES) begin
                $display("Timeout: result_valid never arrived for %s", name);
                stop_on_failure();
            end
            @(negedge clock);
        end
        if (waited != 0) begin
            $display("result_valid for %s came %0d cycles late", name, waited);
            stop_on_failure();
        end
    endtask

    task automatic run_table();
        int i;
        @(posedge clock);
        drive_entry(0);
        for (i = 0; i < tbl.size(); i++) begin
            @(posedge clock);                  // DUT captures entry i
            dbg_addr <= tbl[i].wa;
            if (i + 1 < tbl.size() && tbl[i+1].b2b)
                drive_entry(i + 1);
            else
                valid <= 1'b0;
            wait_result(tbl[i].name);
            check_word(tbl[i].name, tbl[i].exp_res, result);
            check_zero(tbl[i].name, tbl[i].exp_zero, zero);
            check_word({tbl[i].name, "_reg"}, tbl[i].exp_dbg, dbg_data);
            if (i + 1 < tbl.size() && !tbl[i+1].b2b) begin
                @(posedge clock);
                drive_entry(i + 1);
                @(negedge clock);              // Pulse must be gone in the idle cycle
                if (result_valid) begin
                    $display("result_valid stayed high after %s", tbl[i].name);
                    stop_on_failure();
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    task automatic build_table();
        int i;
        add_entry("addi_neg",   mips_pkg::ALU_ADDI, 0,  0,  1,  16'hFFFB, 1, 0, 32'hFFFF_FFFB, 0);
        add_entry("addi_pos",   mips_pkg::ALU_ADDI, 0,  0,  2,  16'h000C, 1, 0, 32'h0000_000C, 0);
        add_entry("subi_neg",   mips_pkg::ALU_SUBI, 2,  0,  3,  16'hFFFD, 1, 0, 32'h0000_000F, 0);
        add_entry("addi_sp",    mips_pkg::ALU_ADDI, 29, 0,  4,  16'hFF00, 1, 0, 32'h0000_0100, 0);
        add_entry("add",        mips_pkg::ALU_ADD,  1,  2,  5,  16'h0000, 1, 0, 32'h0000_0007, 0);
        add_entry("sub_zero",   mips_pkg::ALU_SUB,  2,  2,  6,  16'h0000, 1, 0, 32'h0000_0000, 1);
        add_entry("sub_wrap",   mips_pkg::ALU_SUB,  2,  3,  7,  16'h0000, 1, 0, 32'hFFFF_FFFD, 0);
        add_entry("and",        mips_pkg::ALU_AND,  1,  3,  8,  16'h0000, 1, 0, 32'h0000_000B, 0);
        add_entry("or",         mips_pkg::ALU_OR,   1,  2,  9,  16'h0000, 1, 0, 32'hFFFF_FFFF, 0);
        add_entry("slt_false",  mips_pkg::ALU_SLT,  1,  2,  10, 16'h0000, 1, 0, 32'h0000_0000, 1);
        add_entry("slt_true",   mips_pkg::ALU_SLT,  2,  1,  11, 16'h0000, 1, 0, 32'h0000_0001, 0);
        add_entry("write_r0",   mips_pkg::ALU_ADD,  1,  2,  0,  16'h0000, 1, 0, 32'h0000_0007, 0);
        add_entry("b2b_first",  mips_pkg::ALU_ADDI, 2,  0,  13, 16'h0010, 1, 0, 32'h0000_001C, 0);
        add_entry("b2b_second", mips_pkg::ALU_ADD,  13, 13, 14, 16'h0000, 1, 1, 32'h0000_0038, 0);
        add_entry("b2b_third",  mips_pkg::ALU_SUBI, 14, 0,  15, 16'h0038, 1, 1, 32'h0000_0000, 1);
        add_entry("mult",       mips_pkg::ALU_MULT, 1,  4,  5,  16'h0000, 1, 0, 32'h0000_0000, 1);
        add_entry("mfhi_mult",  mips_pkg::ALU_MFHI, 0,  0,  16, 16'h0000, 1, 1, 32'h0000_00FF, 0);
        add_entry("mflo_mult",  mips_pkg::ALU_MFLO, 0,  0,  17, 16'h0000, 1, 0, 32'hFFFF_FB00, 0);
        add_entry("div",        mips_pkg::ALU_DIV,  4,  3,  8,  16'h0000, 1, 0, 32'h0000_0000, 1);
        add_entry("mfhi_div",   mips_pkg::ALU_MFHI, 0,  0,  18, 16'h0000, 1, 1, 32'h0000_0011, 0);
        add_entry("mflo_div",   mips_pkg::ALU_MFLO, 0,  0,  19, 16'h0000, 1, 0, 32'h0000_0001, 0);
        add_entry("div_zero",   mips_pkg::ALU_DIV,  4,  0,  7,  16'h0000, 1, 0, 32'h0000_0000, 1);
        add_entry("mfhi_div0",  mips_pkg::ALU_MFHI, 0,  0,  20, 16'h0000, 1, 0, 32'h0000_0000, 1);
        add_entry("mflo_div0",  mips_pkg::ALU_MFLO, 0,  0,  21, 16'h0000, 1, 0, 32'h0000_0000, 1);
        add_entry("pass",       mips_pkg::ALU_PASS, 29, 0,  22, 16'h0000, 1, 0, 32'h0000_0200, 0);
        add_entry("undefined",  4'd13,              1,  2,  22, 16'h0000, 1, 0, 32'h0000_0000, 1);
        // Random R-type ops with expected values filled in at issue
        for (i = 0; i < RAND_OPS; i++) begin
            add_entry($sformatf("rand_%0d", i),
                      mips_pkg::alu_sel_t'(mips_pkg::ALU_ADD + $urandom_range(3)),
                      $urandom_range(31), $urandom_range(31), $urandom_range(31),
                      '0, 1'b1, 1'b0, '0, 1'b0);
            tbl[tbl.size()-1].use_model = 1'b1;
        end
    endtask

    initial begin
        int i;
        void'($urandom(32'h3530d5da));
        clock    = 1'b0;
        reset    = 1'b1;
        valid    = 1'b0;
        op       = '0;
        ra0      = '0;
        ra1      = '0;
        wa       = '0;
        imm      = '0;
        write    = 1'b0;
        dbg_addr = '0;
        model_hi = '0;
        model_lo = '0;
        for (i = 0; i < `MIPS_REG_COUNT; i++)
            model[i] = '0;
        model[`MIPS_REG_SP] = `MIPS_SP_RESET;   // Stack top after reset
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        check_word("reset_result", '0, result);
        check_zero("reset_zero", 1'b0, zero);
        // Walk the debug port over every register
        for (i = 0; i < `MIPS_REG_COUNT; i++) begin
            @(posedge clock);
            dbg_addr <= mips_pkg::reg_addr_t'(i);
            @(negedge clock);
            check_word($sformatf("reset_r%0d", i), model[i], dbg_data);
            if (result_valid) begin
                $display("result_valid went high before any operation was issued");
                stop_on_failure();
            end
        end
        build_table();
        run_table();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: rtl/mips_exec_top.sv
`timescale 1ns/100ps
`include "mips_defs.svh"

module mips_exec_top (
    input  logic                clock,
    input  logic                reset,
    input  logic                valid,
    input  mips_pkg::alu_sel_t  op,
    input  mips_pkg::reg_addr_t ra0,
    input  mips_pkg::reg_addr_t ra1,
    input  mips_pkg::reg_addr_t wa,
    input  mips_pkg::imm_t      imm,
    input  logic                write,
    input  mips_pkg::reg_addr_t dbg_addr,
    output mips_pkg::word_t     dbg_data,
    output mips_pkg::word_t     result,
    output logic                zero,
    output logic                result_valid
);

    exec_if iss_bus ();   // Decoded op into execute
    rf_if   rf_bus  ();   // Execute to register file

    // Issue side straight from the ports
    assign iss_bus.valid = valid;
    assign iss_bus.op    = op;
    assign iss_bus.ra0   = ra0;
    assign iss_bus.ra1   = ra1;
    assign iss_bus.wa    = wa;
    assign iss_bus.imm   = imm;
    assign iss_bus.write = write;

    // Validation port, combinational
    assign rf_bus.ra2 = dbg_addr;
    assign dbg_data   = rf_bus.rd2;

    register_file i_register_file (
        .clock (clock),
        .reset (reset),
        .rf    (rf_bus.owner)
    );

    execute_stage i_execute_stage (
        .clock        (clock),
        .reset        (reset),
        .iss          (iss_bus.execute),
        .rf           (rf_bus.user),
        .result       (result),
        .zero         (zero),
        .result_valid (result_valid)
    );

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/100ps
`include "mips_defs.svh"

module execute_stage (
    input  logic            clock,
    input  logic            reset,
    exec_if.execute         iss,
    rf_if.user              rf,
    output mips_pkg::word_t result,
    output logic            zero,
    output logic            result_valid
);

    mips_pkg::word_t imm_ext;    // Sign-extended immediate
    mips_pkg::word_t op_a, op_b;
    mips_pkg::word_t alu_y;
    logic            alu_zero;
    logic            use_imm;
    logic            op_writes;  // Op produces a register result

    ////////////////////////////////////////
    // Operand select
    ////////////////////////////////////////

    assign rf.ra0 = iss.ra0;
    assign rf.ra1 = iss.ra1;

    assign imm_ext = {{(`MIPS_WORD_W-`MIPS_IMM_W){iss.imm[`MIPS_IMM_W-1]}}, iss.imm};

    assign use_imm = (iss.op == mips_pkg::ALU_ADDI) || (iss.op == mips_pkg::ALU_SUBI);
    assign op_a    = rf.rd0;
    assign op_b    = use_imm ? imm_ext : rf.rd1;   // I-type vs R-type

    alu i_alu (
        .clock  (clock),
        .reset  (reset),
        .enable (iss.valid),
        .a      (op_a),
        .b      (op_b),
        .sel    (iss.op),
        .y      (alu_y),
        .zero   (alu_zero)
    );

    ////////////////////////////////////////
    // Write-back
    ////////////////////////////////////////

    // MULT, DIV and 12..15 never write
    always_comb begin
        case (iss.op)
            mips_pkg::ALU_MULT, mips_pkg::ALU_DIV: op_writes = 1'b0;
            default: op_writes = (iss.op <= mips_pkg::ALU_PASS);
        endcase
    end

    // Lands on the same edge as result capture
    assign rf.we = iss.valid && iss.write && op_writes;
    assign rf.wa = iss.wa;
    assign rf.wd = alu_y;

    ////////////////////////////////////////
    // Result registers
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            result       <= '0;
            zero         <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= iss.valid;    // One-cycle pulse per op
            if (iss.valid) begin
                result <= alu_y;
                zero   <= alu_zero;
            end
        end
    end

endmodule

// File: rtl/alu.sv
`timescale 1ns/100ps
`include "mips_defs.svh"

module alu (
    input  logic               clock,
    input  logic               reset,
    input  logic               enable,   // Issue strobe
    input  mips_pkg::word_t    a,
    input  mips_pkg::word_t    b,
    input  mips_pkg::alu_sel_t sel,
    output mips_pkg::word_t    y,
    output logic               zero
);

    logic [2*`MIPS_WORD_W-1:0] product;    // Full unsigned MULT result
    mips_pkg::word_t           quotient;
    mips_pkg::word_t           remainder;
    mips_pkg::word_t           hi_q, lo_q;  // Special purpose regs
    logic                      hi_lo_load;

    ////////////////////////////////////////
    // Multiply and divide
    ////////////////////////////////////////

    assign product = {{`MIPS_WORD_W{1'b0}}, a} * {{`MIPS_WORD_W{1'b0}}, b};

    // Divide by zero gives zero for both
    assign quotient  = (b == '0) ? '0 : a / b;
    assign remainder = (b == '0) ? '0 : a % b;

    // Only MULT and DIV touch HI/LO
    assign hi_lo_load = enable &&
                        (sel == mips_pkg::ALU_MULT || sel == mips_pkg::ALU_DIV);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (hi_lo_load) begin
            if (sel == mips_pkg::ALU_MULT) begin
                hi_q <= product[2*`MIPS_WORD_W-1:`MIPS_WORD_W];   // Upper half
                lo_q <= product[`MIPS_WORD_W-1:0];               // Lower half
            end else begin
                hi_q <= quotient;
                lo_q <= remainder;
            end
        end
    end

    ////////////////////////////////////////
    // Result mux
    ////////////////////////////////////////

    always_comb begin
        y = '0;   // MULT, DIV and undefined codes
        case (sel)
            mips_pkg::ALU_ADDI: y = a + b;
            mips_pkg::ALU_SUBI: y = a - b;
            mips_pkg::ALU_ADD:  y = a + b;
            mips_pkg::ALU_SUB:  y = a - b;
            mips_pkg::ALU_AND:  y = a & b;
            mips_pkg::ALU_OR:   y = a | b;
            mips_pkg::ALU_SLT:  y = {{(`MIPS_WORD_W-1){1'b0}}, (a < b)};   // Unsigned
            mips_pkg::ALU_MFHI: y = hi_q;
            mips_pkg::ALU_MFLO: y = lo_q;
            mips_pkg::ALU_PASS: y = a;
            default:            y = '0;
        endcase
    end

    // Flag follows y, including the forced zeros
    assign zero = (y == '0);

endmodule

// File: rtl/register_file.sv
`timescale 1ns/100ps
`include "mips_defs.svh"

module register_file (
    input logic clock,
    input logic reset,
    rf_if.owner rf
);

    mips_pkg::word_t regs [`MIPS_REG_COUNT];   // Storage array

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            regs[`MIPS_REG_SP] <= `MIPS_SP_RESET;   // Stack starts here
        end else if (rf.we && rf.wa != '0) begin
            regs[rf.wa] <= rf.wd;                 // $zero never stored
        end
    end

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////

    // Combinational reads with index 0 hardwired to zero
    assign rf.rd0 = (rf.ra0 == '0) ? '0 : regs[rf.ra0];   // Operand a
    assign rf.rd1 = (rf.ra1 == '0) ? '0 : regs[rf.ra1];   // Operand b
    assign rf.rd2 = (rf.ra2 == '0) ? '0 : regs[rf.ra2];   // Debug read

endmodule

// File: rtl/mips_ifs.sv
`timescale 1ns/100ps
`include "mips_defs.svh"

////////////////////////////////////////
// Issue bus, top level to execute
////////////////////////////////////////

interface exec_if;
    logic                 valid;    // One strobe per op
    mips_pkg::alu_sel_t   op;
    mips_pkg::reg_addr_t  ra0;      // Source for operand a
    mips_pkg::reg_addr_t  ra1;      // Source for operand b
    mips_pkg::reg_addr_t  wa;       // Destination
    mips_pkg::imm_t       imm;
    logic                 write;    // Result goes to wa

    modport issue   (output valid, op, ra0, ra1, wa, imm, write);
    modport execute (input  valid, op, ra0, ra1, wa, imm, write);
endinterface

////////////////////////////////////////
// Register file access
////////////////////////////////////////

interface rf_if;
    logic                 we;
    mips_pkg::reg_addr_t  wa;
    mips_pkg::word_t      wd;
    mips_pkg::reg_addr_t  ra0, ra1;
    mips_pkg::word_t      rd0, rd1;
    mips_pkg::reg_addr_t  ra2;      // Validation port
    mips_pkg::word_t      rd2;

    // Execute stage side
    modport user  (output we, wa, wd, ra0, ra1, input rd0, rd1);
    // Storage side, third port driven from the top level
    modport owner (input we, wa, wd, ra0, ra1, ra2, output rd0, rd1, rd2);
endinterface

// File: rtl/mips_pkg.sv
`include "mips_defs.svh"

package mips_pkg;

    // Vector types for the execute slice
    typedef logic [`MIPS_WORD_W-1:0]     word_t;
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`MIPS_IMM_W-1:0]      imm_t;
    typedef logic [3:0]                  alu_sel_t;   // 12..15 undefined

    ////////////////////////////////////////
    // ALU op codes
    ////////////////////////////////////////

    parameter alu_sel_t ALU_ADDI = 4'd0;    // a + sext(imm)
    parameter alu_sel_t ALU_SUBI = 4'd1;    // a - sext(imm)
    parameter alu_sel_t ALU_ADD  = 4'd2;
    parameter alu_sel_t ALU_SUB  = 4'd3;
    parameter alu_sel_t ALU_AND  = 4'd4;
    parameter alu_sel_t ALU_OR   = 4'd5;
    parameter alu_sel_t ALU_SLT  = 4'd6;    // Unsigned compare
    parameter alu_sel_t ALU_MULT = 4'd7;    // Writes HI/LO only
    parameter alu_sel_t ALU_DIV  = 4'd8;    // Writes HI/LO only
    parameter alu_sel_t ALU_MFHI = 4'd9;
    parameter alu_sel_t ALU_MFLO = 4'd10;
    parameter alu_sel_t ALU_PASS = 4'd11;   // Operand a straight through

endpackage

// File: rtl/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

`define MIPS_WORD_W      32        // Data word
`define MIPS_REG_ADDR_W  5         // Register index
`define MIPS_IMM_W       16        // Raw immediate from decode

////////////////////////////////////////
// Register file layout
////////////////////////////////////////

`define MIPS_REG_COUNT   32
`define MIPS_REG_SP      29        // $sp
`define MIPS_SP_RESET    32'h200   // Initial stack top

`endif
